// ==== common/mmq_consts.svh ====
`ifndef MMQ_CONSTS_SVH
`define MMQ_CONSTS_SVH

// lanes per vector, also rows per weight matrix
`define MMQ_N 8

// sub-units, each with its own weights and parameters
`define MMQ_SUB_NUM 2
`define MMQ_SUB_W 1

// read requests allowed in flight
`define MMQ_RD_CREDITS 4

// scale is unsigned 8.8 fixed point
`define MMQ_SCALE_SHIFT 8

// widths
`define MMQ_ADDR_W 32
`define MMQ_ACC_W 24
`define MMQ_LANE_W 8
`define MMQ_ROW_W 3

`endif

// ==== common/mmq_pkg.sv ====
`default_nettype none

package mmq_pkg;

`include "mmq_consts.svh"

    // one memory word, weight row, input or output vector
    typedef logic [`MMQ_N-1:0][`MMQ_LANE_W-1:0] mmq_vec_t;

    // one bit per sub-unit
    typedef logic [`MMQ_SUB_NUM-1:0] mmq_sub_mask_t;

    //////////////////////////////////////////////////////////////
    // external read port
    //////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic [`MMQ_ADDR_W-1:0] addr;
    } mmq_rd_req_t;

    typedef struct packed {
        logic     valid;
        mmq_vec_t data;
    } mmq_rd_resp_t;

    //////////////////////////////////////////////////////////////
    // block contents
    //////////////////////////////////////////////////////////////

    // header word layout, lsb first: scale, z_x, z_w, zero
    typedef struct packed {
        logic [`MMQ_LANE_W-1:0] zero;
        logic [`MMQ_LANE_W-1:0] z_w;
        logic [`MMQ_LANE_W-1:0] z_x;
        logic [15:0]            scale;
    } mmq_quant_t;

    // row write from the fetcher towards the weight RAMs
    typedef struct packed {
        logic                  we;
        logic [`MMQ_ROW_W-1:0] addr;
        mmq_vec_t              row;
    } mmq_row_wr_t;

endpackage

`default_nettype wire

// ==== exec/mmq_exec.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

module mmq_exec (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_start,
    input  wire  mmq_pkg::mmq_vec_t     i_x,
    input  wire  mmq_pkg::mmq_quant_t   i_quant,
    output logic [`MMQ_ROW_W-1:0]       o_w_addr,
    input  wire  mmq_pkg::mmq_vec_t     i_w_data,
    output mmq_pkg::mmq_vec_t           o_y,
    output logic                        o_done
);

    import mmq_pkg::*;

    // accumulator times 17-bit signed scale
    localparam int PROD_W   = `MMQ_ACC_W + 17;
    localparam int LAST_ROW = `MMQ_N - 1;

    mmq_vec_t                  x_q;
    mmq_quant_t                quant_q;
    logic                      issue_busy;
    logic [`MMQ_ROW_W-1:0]     row_cnt;
    logic                      rd_v;
    logic [`MMQ_ROW_W-1:0]     rd_row;
    logic                      dot_v;
    logic [`MMQ_ROW_W-1:0]     dot_row;
    logic                      run_busy;
    logic signed [`MMQ_ACC_W-1:0] dot_sum;
    logic signed [`MMQ_ACC_W-1:0] dot_q;
    logic signed [PROD_W-1:0]  scaled;
    logic signed [PROD_W-1:0]  requant;
    logic [`MMQ_LANE_W-1:0]    lane_sat;

    // busy until the last row has left the pipe
    assign run_busy = issue_busy | rd_v | dot_v;
    assign o_w_addr = row_cnt;

    ////////////////////////////////////////////////////////////
    // row sequencing and pipeline control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            issue_busy <= 1'b0;
            row_cnt    <= '0;
            rd_v       <= 1'b0;
            rd_row     <= '0;
            dot_v      <= 1'b0;
            dot_row    <= '0;
            o_done     <= 1'b0;
            o_y        <= '0;
        end else begin
            if (i_start && !run_busy) begin
                issue_busy <= 1'b1;
                row_cnt    <= '0;
            end else if (issue_busy) begin
                row_cnt <= row_cnt + 1'b1;
                if (row_cnt == `MMQ_ROW_W'(LAST_ROW))
                    issue_busy <= 1'b0;
            end

            // ram data lines up with rd_v
            rd_v    <= issue_busy;
            rd_row  <= row_cnt;
            dot_v   <= rd_v;
            dot_row <= rd_row;

            if (dot_v)
                o_y[dot_row] <= lane_sat;
            o_done <= dot_v && (dot_row == `MMQ_ROW_W'(LAST_ROW));
        end
    end

    always_ff @(posedge clk) begin
        if (i_start && !run_busy) begin
            x_q     <= i_x;
            quant_q <= i_quant;
        end
        if (rd_v)
            dot_q <= dot_sum;
    end

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    // zero-point corrected dot product, all terms signed
    always_comb begin
        dot_sum = '0;
        for (int k = 0; k < `MMQ_N; k++) begin
            dot_sum = dot_sum
                + (($signed({1'b0, x_q[k]}) - $signed({1'b0, quant_q.z_x}))
                * ($signed({1'b0, i_w_data[k]}) - $signed({1'b0, quant_q.z_w})));
        end
    end

    // arithmetic shift floors towards minus infinity
    always_comb begin
        scaled  = (dot_q * $signed({1'b0, quant_q.scale})) >>> `MMQ_SCALE_SHIFT;
        requant = scaled + $signed({1'b0, quant_q.zero});
        if (requant < 0)
            lane_sat = '0;
        else if (requant > 255)
            lane_sat = '1;
        else
            lane_sat = requant[`MMQ_LANE_W-1:0];
    end

endmodule

`default_nettype wire

// ==== fetch/mmq_fetch.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

module mmq_fetch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          i_start,
    input  wire  [`MMQ_ADDR_W-1:0]       i_fetch_addr,
    output mmq_pkg::mmq_rd_req_t         o_rd_req,
    input  wire  mmq_pkg::mmq_rd_resp_t  i_rd_resp,
    output mmq_pkg::mmq_quant_t          o_quant,
    output logic                         o_quant_valid,
    output mmq_pkg::mmq_row_wr_t         o_row_wr,
    output logic                         o_fetch_done
);

    import mmq_pkg::*;

    // header plus one word per row
    localparam int WORDS = `MMQ_N + 1;
    localparam int CNT_W = $clog2(WORDS + 1);
    localparam int CRD_W = $clog2(`MMQ_RD_CREDITS + 1);

    logic                   busy;
    logic [`MMQ_ADDR_W-1:0] base_addr;
    logic [CNT_W-1:0]       req_cnt;
    logic [CNT_W-1:0]       resp_cnt;
    logic [CRD_W-1:0]       credits;
    logic                   req_fire;
    logic                   resp_fire;
    logic [`MMQ_N*`MMQ_LANE_W-1:0] resp_word;
    logic                   row_we_q;
    logic [`MMQ_ROW_W-1:0]  row_addr_q;
    mmq_vec_t               row_data_q;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    // stall at zero credits
    assign req_fire  = busy && (req_cnt < CNT_W'(WORDS)) && (credits != '0);
    assign resp_fire = busy && i_rd_resp.valid;
    assign resp_word = i_rd_resp.data;

    assign o_rd_req = mmq_rd_req_t'{valid: req_fire,
                                    addr:  base_addr + `MMQ_ADDR_W'(req_cnt)};

    assign o_row_wr = mmq_row_wr_t'{we: row_we_q, addr: row_addr_q, row: row_data_q};

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            req_cnt       <= '0;
            resp_cnt      <= '0;
            credits       <= CRD_W'(`MMQ_RD_CREDITS);
            o_quant_valid <= 1'b0;
            row_we_q      <= 1'b0;
            o_fetch_done  <= 1'b0;
        end else begin
            // every response hands a credit back
            credits <= credits - CRD_W'(req_fire) + CRD_W'(i_rd_resp.valid);

            if (i_start && !busy) begin
                busy     <= 1'b1;
                req_cnt  <= '0;
                resp_cnt <= '0;
            end else begin
                if (req_fire)
                    req_cnt <= req_cnt + 1'b1;
                if (resp_fire) begin
                    resp_cnt <= resp_cnt + 1'b1;
                    if (resp_cnt == CNT_W'(WORDS - 1))
                        busy <= 1'b0;
                end
            end

            // word 0 is the header, the rest are rows
            o_quant_valid <= resp_fire && (resp_cnt == '0);
            row_we_q      <= resp_fire && (resp_cnt != '0);
            o_fetch_done  <= row_we_q && (row_addr_q == `MMQ_ROW_W'(`MMQ_N - 1));
        end
    end

    ////////////////////////////////////////////////////////////
    // payload
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_start && !busy)
            base_addr <= i_fetch_addr;
        if (resp_fire) begin
            row_addr_q <= `MMQ_ROW_W'(resp_cnt - 1'b1);
            row_data_q <= i_rd_resp.data;
        end
        if (resp_fire && (resp_cnt == '0))
            o_quant <= mmq_quant_t'(resp_word[$bits(mmq_quant_t)-1:0]);
    end

endmodule

`default_nettype wire

// ==== rtl/mmq_quant_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

// quantization parameter sets, one slot per sub-unit
module mmq_quant_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_load,
    input  wire  [`MMQ_SUB_W-1:0]       i_sub_idx,
    input  wire  mmq_pkg::mmq_quant_t   i_quant,
    output mmq_pkg::mmq_quant_t         o_quant [`MMQ_SUB_NUM]
);

    ////////////////////////////////////////////////////////////
    // slot update
    ////////////////////////////////////////////////////////////

    // slot index was registered when the fetch started
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `MMQ_SUB_NUM; s++) begin
                o_quant[s] <= '0;
            end
        end else if (i_load) begin
            o_quant[i_sub_idx] <= i_quant;
        end
    end

    // each executor latches its own slot at start, so a reload
    // during a run only affects the next run of that sub-unit

endmodule

`default_nettype wire

// ==== rtl/mmq_top.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

module mmq_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  mmq_pkg::mmq_sub_mask_t i_fetch,
    input  wire  [`MMQ_ADDR_W-1:0]       i_fetch_addr,
    output wire                          o_fetch_done,
    output wire  mmq_pkg::mmq_rd_req_t   o_rd_req,
    input  wire  mmq_pkg::mmq_rd_resp_t  i_rd_resp,
    input  wire  mmq_pkg::mmq_sub_mask_t i_x_we,
    input  wire  mmq_pkg::mmq_vec_t      i_x_data,
    input  wire  mmq_pkg::mmq_sub_mask_t i_exec,
    output wire  mmq_pkg::mmq_sub_mask_t o_exec_done,
    input  wire  mmq_pkg::mmq_sub_mask_t i_y_re,
    output mmq_pkg::mmq_vec_t            o_y_data
);

    import mmq_pkg::*;

    logic [`MMQ_SUB_W-1:0] fetch_idx_nxt;
    logic [`MMQ_SUB_W-1:0] fetch_idx;
    mmq_quant_t            fetch_quant;
    logic                  quant_valid;
    mmq_row_wr_t           row_wr;
    mmq_quant_t            sub_quant [`MMQ_SUB_NUM];
    mmq_vec_t              x_reg     [`MMQ_SUB_NUM];
    mmq_vec_t              y_vec     [`MMQ_SUB_NUM];
    mmq_vec_t              ram_rdata [`MMQ_SUB_NUM];
    logic [`MMQ_ROW_W-1:0] exec_addr [`MMQ_SUB_NUM];

    ////////////////////////////////////////////////////////////
    // fetch path
    ////////////////////////////////////////////////////////////

    // lowest set bit picks the sub-unit
    always_comb begin
        fetch_idx_nxt = '0;
        for (int s = `MMQ_SUB_NUM - 1; s >= 0; s--) begin
            if (i_fetch[s])
                fetch_idx_nxt = `MMQ_SUB_W'(s);
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            fetch_idx <= '0;
        else if (|i_fetch)
            fetch_idx <= fetch_idx_nxt;
    end

    mmq_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_start       (|i_fetch),
        .i_fetch_addr  (i_fetch_addr),
        .o_rd_req      (o_rd_req),
        .i_rd_resp     (i_rd_resp),
        .o_quant       (fetch_quant),
        .o_quant_valid (quant_valid),
        .o_row_wr      (row_wr),
        .o_fetch_done  (o_fetch_done)
    );

    mmq_quant_regs u_quant_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_load    (quant_valid),
        .i_sub_idx (fetch_idx),
        .i_quant   (fetch_quant),
        .o_quant   (sub_quant)
    );

    ////////////////////////////////////////////////////////////
    // sub-units
    ////////////////////////////////////////////////////////////

    for (genvar s = 0; s < `MMQ_SUB_NUM; s++) begin : g_sub
        logic                  ram_we;
        logic [`MMQ_ROW_W-1:0] ram_addr;

        // a row write takes the port over the executor
        assign ram_we   = row_wr.we && (fetch_idx == `MMQ_SUB_W'(s));
        assign ram_addr = ram_we ? row_wr.addr : exec_addr[s];

        mmq_weight_ram u_ram (
            .clk     (clk),
            .i_we    (ram_we),
            .i_addr  (ram_addr),
            .i_wdata (row_wr.row),
            .o_rdata (ram_rdata[s])
        );

        mmq_exec u_exec (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_start  (i_exec[s]),
            .i_x      (x_reg[s]),
            .i_quant  (sub_quant[s]),
            .o_w_addr (exec_addr[s]),
            .i_w_data (ram_rdata[s]),
            .o_y      (y_vec[s]),
            .o_done   (o_exec_done[s])
        );
    end

    ////////////////////////////////////////////////////////////
    // input vectors and readout
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `MMQ_SUB_NUM; s++) begin
                x_reg[s] <= '0;
            end
            o_y_data <= '0;
        end else begin
            for (int s = 0; s < `MMQ_SUB_NUM; s++) begin
                if (i_x_we[s])
                    x_reg[s] <= i_x_data;
                // later index overrides, highest set bit wins
                if (i_y_re[s])
                    o_y_data <= y_vec[s];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mmq_weight_ram.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

module mmq_weight_ram (
    input  wire                       clk,
    input  wire                       i_we,
    input  wire  [`MMQ_ROW_W-1:0]     i_addr,
    input  wire  mmq_pkg::mmq_vec_t   i_wdata,
    output mmq_pkg::mmq_vec_t         o_rdata
);

    import mmq_pkg::*;

    // one row per output lane
    mmq_vec_t mem [`MMQ_N];

    // single port, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_addr] <= i_wdata;
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mmq -f vlog.f --Mdir obj_dir -o tb_mmq_sim

./obj_dir/tb_mmq_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
exit 0

// ==== tests/tb_mmq.sv ====
`default_nettype none
`timescale 1ns/10ps

`include "mmq_consts.svh"

module tb_mmq;

    import mmq_pkg::*;

    // six tests of roughly 250 cycles each
    localparam int TIMEOUT_CYCLES = 6 * 250;

    logic          clk;
    logic          rst_n;
    mmq_sub_mask_t fetch;
    logic [31:0]   fetch_addr;
    logic          fetch_done;
    mmq_rd_req_t   rd_req;
    mmq_rd_resp_t  rd_resp;
    mmq_sub_mask_t x_we;
    mmq_vec_t      x_data;
    mmq_sub_mask_t exec;
    mmq_sub_mask_t exec_done;
    mmq_sub_mask_t y_re;
    mmq_vec_t      y_data;

    integer        seed = 32'h28b5702c;
    int            cycle = 0;
    int            errors = 0;
    int            checks = 0;
    int            outstanding = 0;
    int            lo_delay = 0;
    int            fetch_done_cnt = 0;
    int            exec_done_cnt [`MMQ_SUB_NUM];
    logic [31:0]   req_log [$];
    logic [31:0]   pend_addr [$];
    int            pend_ready [$];

    // memory image and the expected sub-unit contents
    mmq_vec_t      mem [256];
    mmq_vec_t      stage_w [`MMQ_N];
    mmq_quant_t    stage_q;
    mmq_vec_t      exp_w [`MMQ_SUB_NUM][`MMQ_N];
    mmq_quant_t    exp_q [`MMQ_SUB_NUM];
    mmq_vec_t      exp_x [`MMQ_SUB_NUM];

    mmq_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_fetch      (fetch),
        .i_fetch_addr (fetch_addr),
        .o_fetch_done (fetch_done),
        .o_rd_req     (rd_req),
        .i_rd_resp    (rd_resp),
        .i_x_we       (x_we),
        .i_x_data     (x_data),
        .i_exec       (exec),
        .o_exec_done  (exec_done),
        .i_y_re       (y_re),
        .o_y_data     (y_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES)
            @(posedge clk);
        $display("timeout: no result after %0d cycles", cycle);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////
    // memory model and event counters
    //////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n) begin
            if (rd_req.valid) begin
                if (outstanding >= `MMQ_RD_CREDITS) begin
                    $display("ERROR t=%0t: read request issued with %0d outstanding",
                             $time, outstanding);
                    errors++;
                end
                req_log.push_back(rd_req.addr);
                pend_addr.push_back(rd_req.addr);
                pend_ready.push_back(cycle + lo_delay + int'($unsigned($random(seed)) % 4));
            end
            outstanding = outstanding + int'(rd_req.valid) - int'(rd_resp.valid);
            if (fetch_done)
                fetch_done_cnt++;
            for (int s = 0; s < `MMQ_SUB_NUM; s++) begin
                if (exec_done[s])
                    exec_done_cnt[s]++;
            end
        end
    end

    // responses leave in request order once their delay is over
    always @(negedge clk) begin
        if (pend_addr.size() > 0 && pend_ready[0] <= cycle) begin
            rd_resp.valid = 1'b1;
            rd_resp.data  = mem[pend_addr[0][7:0]];
            void'(pend_addr.pop_front());
            void'(pend_ready.pop_front());
        end else begin
            rd_resp = '0;
        end
    end

    //////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////

    task automatic check_eq(input string name, input logic [63:0] act, input logic [63:0] exp);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s: got %h expected %h", $time, name, act, exp);
            errors++;
        end
    endtask

    function automatic mmq_vec_t rand_vec();
        return {$random(seed), $random(seed)};
    endfunction

    // y_j = sat_u8(((sum (x - z_x)(w - z_w)) * scale >>> shift) + zero)
    function automatic mmq_vec_t ref_vec(input int s);
        mmq_vec_t y;
        longint   acc;
        longint   v;
        int       xv;
        int       wv;
        for (int j = 0; j < `MMQ_N; j++) begin
            acc = 0;
            for (int k = 0; k < `MMQ_N; k++) begin
                xv  = int'(exp_x[s][k]) - int'(exp_q[s].z_x);
                wv  = int'(exp_w[s][j][k]) - int'(exp_q[s].z_w);
                acc = acc + longint'(xv) * longint'(wv);
            end
            v = (acc * longint'(exp_q[s].scale)) >>> `MMQ_SCALE_SHIFT;
            v = v + longint'(exp_q[s].zero);
            if (v < 0)
                y[j] = 8'h00;
            else if (v > 255)
                y[j] = 8'hff;
            else
                y[j] = v[7:0];
        end
        return y;
    endfunction

    task automatic stage_random();
        for (int r = 0; r < `MMQ_N; r++)
            stage_w[r] = rand_vec();
        stage_q.scale = 16'(1 + ($unsigned($random(seed)) % 4));
        stage_q.z_x   = 8'($random(seed));
        stage_q.z_w   = 8'($random(seed));
        stage_q.zero  = 8'($random(seed));
    endtask

    // header word first, then one word per row
    task automatic load_block(input logic [31:0] base);
        mem[base[7:0]] = {24'h0, stage_q.zero, stage_q.z_w, stage_q.z_x, stage_q.scale};
        for (int r = 0; r < `MMQ_N; r++)
            mem[8'(base + 32'(r + 1))] = stage_w[r];
    endtask

    task automatic start_fetch(input int s, input logic [31:0] base);
        @(negedge clk);
        fetch      = mmq_sub_mask_t'(1 << s);
        fetch_addr = base;
        @(negedge clk);
        fetch = '0;
    endtask

    task automatic wait_fetch(input int target, input int s);
        int n;
        n = 0;
        while (fetch_done_cnt < target && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (fetch_done_cnt < target) begin
            $display("ERROR t=%0t: fetch into sub %0d never finished", $time, s);
            errors++;
        end
        exp_w[s] = stage_w;
        exp_q[s] = stage_q;
    endtask

    task automatic run_fetch(input int s, input logic [31:0] base);
        int target;
        target = fetch_done_cnt + 1;
        start_fetch(s, base);
        wait_fetch(target, s);
    endtask

    task automatic write_x(input int s, input mmq_vec_t v);
        @(negedge clk);
        x_we   = mmq_sub_mask_t'(1 << s);
        x_data = v;
        @(negedge clk);
        x_we = '0;
        exp_x[s] = v;
    endtask

    task automatic start_exec(input mmq_sub_mask_t mask);
        @(negedge clk);
        exec = mask;
        @(negedge clk);
        exec = '0;
    endtask

    task automatic wait_exec(input int s, input int target);
        int n;
        n = 0;
        while (exec_done_cnt[s] < target && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (exec_done_cnt[s] < target) begin
            $display("ERROR t=%0t: executor %0d never signalled done", $time, s);
            errors++;
        end
    endtask

    task automatic read_y(input int s, output mmq_vec_t v);
        @(negedge clk);
        y_re = mmq_sub_mask_t'(1 << s);
        @(negedge clk);
        y_re = '0;
        v = y_data;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////

    task automatic reset_values();
        int e;
        e = errors;
        check_eq("o_rd_req.valid", 64'(rd_req.valid), 64'd0);
        check_eq("o_fetch_done", 64'(fetch_done), 64'd0);
        check_eq("o_exec_done", 64'(exec_done), 64'd0);
        check_eq("o_y_data", y_data, 64'd0);
        report_test(1, "reset values", e);
    endtask

    task automatic fetch_slow_memory();
        int e;
        int done_before;
        e = errors;
        done_before = fetch_done_cnt;
        lo_delay = 4;
        stage_random();
        load_block(32'h10);
        req_log.delete();
        run_fetch(0, 32'h10);
        repeat (5) @(negedge clk);
        lo_delay = 0;
        check_eq("request count", 64'(req_log.size()), 64'd9);
        foreach (req_log[i])
            check_eq("o_rd_req.addr", 64'(req_log[i]), 64'(32'h10 + 32'(i)));
        check_eq("o_fetch_done pulses", 64'(fetch_done_cnt - done_before), 64'd1);
        report_test(2, "fetch with slow memory", e);
    endtask

    task automatic single_exec();
        int       e;
        int       n;
        mmq_vec_t y;
        e = errors;
        stage_random();
        load_block(32'h20);
        run_fetch(0, 32'h20);
        write_x(0, rand_vec());
        start_exec(2'b01);
        n = 1;
        while (!exec_done[0] && n < 40) begin
            @(negedge clk);
            n++;
        end
        check_eq("o_exec_done[0] latency", 64'(n), 64'd11);
        read_y(0, y);
        check_eq("o_y_data", y, ref_vec(0));
        report_test(3, "single execution", e);
    endtask

    task automatic dual_exec();
        int       e;
        int       t0;
        int       t1;
        mmq_vec_t y;
        e = errors;
        stage_random();
        load_block(32'h40);
        run_fetch(0, 32'h40);
        stage_random();
        load_block(32'h60);
        run_fetch(1, 32'h60);
        write_x(0, rand_vec());
        write_x(1, rand_vec());
        t0 = exec_done_cnt[0] + 1;
        t1 = exec_done_cnt[1] + 1;
        start_exec(2'b11);
        wait_exec(0, t0);
        wait_exec(1, t1);
        read_y(0, y);
        check_eq("o_y_data sub 0", y, ref_vec(0));
        read_y(1, y);
        check_eq("o_y_data sub 1", y, ref_vec(1));
        report_test(4, "both sub-units together", e);
    endtask

    task automatic refetch_during_exec();
        int       e;
        int       t0;
        int       tf;
        mmq_vec_t y;
        e = errors;
        stage_random();
        load_block(32'h80);
        t0 = exec_done_cnt[0] + 1;
        tf = fetch_done_cnt + 1;
        // fetch into sub 1 and run sub 0 from the same edge
        @(negedge clk);
        fetch      = 2'b10;
        fetch_addr = 32'h80;
        exec       = 2'b01;
        @(negedge clk);
        fetch = '0;
        exec  = '0;
        wait_exec(0, t0);
        wait_fetch(tf, 1);
        read_y(0, y);
        check_eq("o_y_data sub 0", y, ref_vec(0));
        t0 = exec_done_cnt[1] + 1;
        start_exec(2'b10);
        wait_exec(1, t0);
        read_y(1, y);
        check_eq("o_y_data sub 1", y, ref_vec(1));
        report_test(5, "re-fetch during execution", e);
    endtask

    task automatic saturation_case();
        int       e;
        int       t0;
        mmq_vec_t y;
        e = errors;
        // even rows overflow and odd rows go negative
        for (int r = 0; r < `MMQ_N; r++)
            stage_w[r] = (r % 2 == 0) ? '1 : '0;
        stage_q.scale = 16'h0100;
        stage_q.z_x   = 8'd0;
        stage_q.z_w   = 8'd128;
        stage_q.zero  = 8'd128;
        load_block(32'hA0);
        run_fetch(0, 32'hA0);
        write_x(0, '1);
        t0 = exec_done_cnt[0] + 1;
        start_exec(2'b01);
        wait_exec(0, t0);
        read_y(0, y);
        check_eq("o_y_data", y, 64'h00ff00ff00ff00ff);
        report_test(6, "saturation", e);
    endtask

    initial begin
        rst_n      = 1'b0;
        fetch      = '0;
        fetch_addr = '0;
        rd_resp    = '0;
        x_we       = '0;
        x_data     = '0;
        exec       = '0;
        y_re       = '0;
        for (int s = 0; s < `MMQ_SUB_NUM; s++)
            exec_done_cnt[s] = 0;
        // fill pattern built from the whole word address
        for (int a = 0; a < 256; a++)
            mem[a] = {~32'(a), 32'(a) * 32'h9e3779b9};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        fetch_slow_memory();
        single_exec();
        dual_exec();
        refetch_during_exec();
        saturation_case();

        $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/mmq_pkg.sv
fetch/mmq_fetch.sv
rtl/mmq_quant_regs.sv
rtl/mmq_weight_ram.sv
exec/mmq_exec.sv
rtl/mmq_top.sv
tests/tb_mmq.sv
